// ==== rob_core_macros.svh ====
`ifndef ROB_CORE_MACROS_SVH
`define ROB_CORE_MACROS_SVH

// reorder buffer sizing
// depth must stay a power of two, pointers wrap on overflow
`define ROB_DEPTH 16
`define ROB_TAG_W 4

// rv32i datapath widths
`define XLEN 32
`define REG_ADDR_W 5

`endif

// ==== rv32i_pkg.sv ====
`include "rob_core_macros.svh"

package rv32i_pkg;

    // coarse operation class, enough for retirement decisions
    // op_nop still occupies a slot and needs a writeback
    typedef enum logic [1:0] {
        op_alu    = 2'd0,
        op_branch = 2'd1,
        op_nop    = 2'd2
    } op_class_e;

    // architectural register index
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

    // one data word
    typedef logic [`XLEN-1:0] xlen_t;

endpackage

// ==== rob_pkg.sv ====
`include "rob_core_macros.svh"

package rob_pkg;

    // entry index handed out at dispatch
    typedef logic [`ROB_TAG_W-1:0] rob_tag_t;

    // slot lifecycle
    // empty -> wait at dispatch, wait -> done at writeback
    typedef enum logic [1:0] {
        st_empty = 2'd0,
        st_wait  = 2'd1,
        st_done  = 2'd2
    } rob_status_e;

    // one slot of the buffer
    typedef struct packed {
        logic                  valid;
        rob_status_e           status;
        rv32i_pkg::op_class_e  op;
        rv32i_pkg::xlen_t      pc;
        rv32i_pkg::reg_addr_t  rd;
        // register file write on retire
        logic                  regf_we;
        // result from the writeback bus
        rv32i_pkg::xlen_t      rd_data;
        // branch outcome, only meaningful for op_branch
        logic                  br_taken;
        rv32i_pkg::xlen_t      br_target;
    } rob_entry_t;

endpackage

// ==== cdb_if.sv ====
`timescale 1ns/100ps
`include "rob_core_macros.svh"

// one writeback bus
// valid is a single-cycle strobe, never stalled
interface cdb_if;

    logic                  valid;
    logic [`ROB_TAG_W-1:0] tag;
    logic [`XLEN-1:0]      data;
    // branch resolution, tied off on the alu bus
    logic                  br_taken;
    logic [`XLEN-1:0]      br_target;

    // execution side drives
    modport source (
        output valid, tag, data, br_taken, br_target
    );

    // reorder buffer listens
    modport rob (
        input valid, tag, data, br_taken, br_target
    );

endinterface

// ==== rob_head_if.sv ====
`timescale 1ns/100ps
`include "rob_core_macros.svh"

// head of the reorder buffer as seen by the commit unit
interface rob_head_if;

    // from rob
    logic                  head_valid;
    rob_pkg::rob_entry_t   head_entry;
    logic [`ROB_TAG_W-1:0] head_tag;

    // from commit unit
    // flush only ever comes with retire
    logic                  retire;
    logic                  flush;
    logic [`XLEN-1:0]      redirect_pc;

    modport rob (
        output head_valid, head_entry, head_tag,
        input  retire, flush
    );

    modport commit (
        input  head_valid, head_entry, head_tag,
        output retire, flush, redirect_pc
    );

endinterface

// ==== rob.sv ====
`timescale 1ns/100ps
`include "rob_core_macros.svh"

module rob (
    input  logic                 clk,
    input  logic                 rst_n_i,

    // dispatch, program order
    input  logic                 dispatch_valid_i,
    input  rv32i_pkg::op_class_e dispatch_op_i,
    input  rv32i_pkg::xlen_t     dispatch_pc_i,
    input  rv32i_pkg::reg_addr_t dispatch_rd_i,
    input  logic                 dispatch_regf_we_i,
    output rob_pkg::rob_tag_t    tag_o,
    output logic                 full_o,

    // writeback buses
    cdb_if.rob                   cdb_alu,
    cdb_if.rob                   cdb_br,

    // commit side
    rob_head_if.rob              head
);

    // count needs one more bit than the tag to tell full from empty
    localparam logic [`ROB_TAG_W:0] DEPTH_CNT = `ROB_DEPTH;

    rob_pkg::rob_entry_t entries [`ROB_DEPTH];
    rob_pkg::rob_entry_t new_entry;

    rob_pkg::rob_tag_t   head_ptr;
    rob_pkg::rob_tag_t   tail_ptr;
    logic [`ROB_TAG_W:0] count;

    logic                dispatch_fire;
    logic                alu_hit;
    logic                br_hit;

    assign full_o = (count == DEPTH_CNT);
    assign tag_o  = tail_ptr;

    // a dispatch in the flush cycle is younger than the branch, drop it
    assign dispatch_fire = dispatch_valid_i && !full_o && !head.flush;

    // tag only match, a stray tag hitting an empty slot falls through
    assign alu_hit = cdb_alu.valid && entries[cdb_alu.tag].valid
                     && (entries[cdb_alu.tag].status == rob_pkg::st_wait);
    assign br_hit  = cdb_br.valid && entries[cdb_br.tag].valid
                     && (entries[cdb_br.tag].status == rob_pkg::st_wait);

    // fresh slot, result fields filled in later by writeback
    always_comb begin
        new_entry         = '0;
        new_entry.valid   = 1'b1;
        new_entry.status  = rob_pkg::st_wait;
        new_entry.op      = dispatch_op_i;
        new_entry.pc      = dispatch_pc_i;
        new_entry.rd      = dispatch_rd_i;
        new_entry.regf_we = dispatch_regf_we_i;
    end

    // head is read straight from the array, commit decides combinationally
    assign head.head_valid = entries[head_ptr].valid;
    assign head.head_entry = entries[head_ptr];
    assign head.head_tag   = head_ptr;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            entries  <= '{default: '0};
            head_ptr <= '0;
            tail_ptr <= '0;
            count    <= '0;
        end else if (head.flush) begin
            // retiring taken branch, everything else is wrong path
            for (int i = 0; i < `ROB_DEPTH; i++) begin
                entries[i].valid  <= 1'b0;
                entries[i].status <= rob_pkg::st_empty;
            end
            head_ptr <= '0;
            tail_ptr <= '0;
            count    <= '0;
        end else begin
            // alu writeback
            if (alu_hit) begin
                entries[cdb_alu.tag].status  <= rob_pkg::st_done;
                entries[cdb_alu.tag].rd_data <= cdb_alu.data;
            end
            // branch writeback, carries the resolved direction too
            if (br_hit) begin
                entries[cdb_br.tag].status    <= rob_pkg::st_done;
                entries[cdb_br.tag].rd_data   <= cdb_br.data;
                entries[cdb_br.tag].br_taken  <= cdb_br.br_taken;
                entries[cdb_br.tag].br_target <= cdb_br.br_target;
            end
            // single step retire
            if (head.retire) begin
                entries[head_ptr].valid  <= 1'b0;
                entries[head_ptr].status <= rob_pkg::st_empty;
                head_ptr                 <= head_ptr + 1'b1;
            end
            // tail slot is free whenever not full
            if (dispatch_fire) begin
                entries[tail_ptr] <= new_entry;
                tail_ptr          <= tail_ptr + 1'b1;
            end
            case ({dispatch_fire, head.retire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // no back-pressure, dispatcher has to watch full_o
    a_no_dispatch_full: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        dispatch_valid_i |-> !full_o
    );

    // execution units write each allocated slot back once
    a_alu_single_wb: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        cdb_alu.valid && entries[cdb_alu.tag].valid
            |-> entries[cdb_alu.tag].status == rob_pkg::st_wait
    );

    a_br_single_wb: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        cdb_br.valid && entries[cdb_br.tag].valid
            |-> entries[cdb_br.tag].status == rob_pkg::st_wait
    );

    // one producer per tag
    a_bus_tag_clash: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        !(cdb_alu.valid && cdb_br.valid && (cdb_alu.tag == cdb_br.tag))
    );

endmodule

// ==== commit_unit.sv ====
`timescale 1ns/100ps
`include "rob_core_macros.svh"

module commit_unit (
    input  logic                 clk,
    input  logic                 rst_n_i,

    rob_head_if.commit           head,

    // register file write port
    output logic                 rf_we_o,
    output rv32i_pkg::reg_addr_t rf_waddr_o,
    output rv32i_pkg::xlen_t     rf_wdata_o,

    // commit report, one cycle after retire
    output logic                 commit_valid_o,
    output rv32i_pkg::reg_addr_t commit_rd_o,
    output rv32i_pkg::xlen_t     commit_data_o,
    output rv32i_pkg::xlen_t     commit_pc_o,
    output logic                 flush_o,
    output rv32i_pkg::xlen_t     redirect_pc_o
);

    // head done, retire this cycle
    assign head.retire = head.head_valid && (head.head_entry.status == rob_pkg::st_done);

    // predicted not-taken, so any taken branch is a mispredict
    assign head.flush = head.retire && (head.head_entry.op == rv32i_pkg::op_branch)
                        && head.head_entry.br_taken;
    assign head.redirect_pc = head.head_entry.br_target;

    // write lands at the same edge as the commit report
    assign rf_we_o    = head.retire && head.head_entry.regf_we && (head.head_entry.rd != '0);
    assign rf_waddr_o = head.head_entry.rd;
    assign rf_wdata_o = head.head_entry.rd_data;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            commit_valid_o <= 1'b0;
            flush_o        <= 1'b0;
        end else begin
            commit_valid_o <= head.retire;
            flush_o        <= head.flush;
        end
    end

    // report payload, held between commits
    always_ff @(posedge clk) begin
        if (head.retire) begin
            commit_rd_o   <= head.head_entry.rd;
            commit_data_o <= head.head_entry.rd_data;
            commit_pc_o   <= head.head_entry.pc;
            redirect_pc_o <= head.redirect_pc;
        end
    end

    // flush rides on a retire and leaves the buffer empty
    a_flush_empties: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        head.flush |-> head.retire ##1 !head.head_valid
    );

    // plain retire moves the head by exactly one slot
    a_head_in_order: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        (head.retire && !head.flush) ##1 head.head_valid
            |-> head.head_tag == ($past(head.head_tag) + 1) % `ROB_DEPTH
    );

endmodule

// ==== arch_regfile.sv ====
`timescale 1ns/100ps
`include "rob_core_macros.svh"

module arch_regfile (
    input  logic                 clk,
    input  logic                 rst_n_i,

    // write port from commit
    input  logic                 we_i,
    input  rv32i_pkg::reg_addr_t waddr_i,
    input  rv32i_pkg::xlen_t     wdata_i,

    // async read port
    input  rv32i_pkg::reg_addr_t raddr_i,
    output rv32i_pkg::xlen_t     rdata_o
);

    localparam int NUM_REGS = 1 << `REG_ADDR_W;

    // x0 has no storage
    rv32i_pkg::xlen_t regs [1:NUM_REGS-1];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 1; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (waddr_i != '0)) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // x0 always reads zero
    assign rdata_o = (raddr_i == '0) ? '0 : regs[raddr_i];

endmodule

// ==== rob_core_top.sv ====
`timescale 1ns/100ps
`include "rob_core_macros.svh"

module rob_core_top (
    input  logic                  clk,
    input  logic                  rst_n_i,

    // dispatch
    input  logic                  dispatch_valid_i,
    input  rv32i_pkg::op_class_e  dispatch_op_i,
    input  logic [`XLEN-1:0]      dispatch_pc_i,
    input  logic [`REG_ADDR_W-1:0] dispatch_rd_i,
    input  logic                  dispatch_regf_we_i,
    output logic [`ROB_TAG_W-1:0] tag_o,
    output logic                  full_o,

    // alu writeback
    input  logic                  alu_valid_i,
    input  logic [`ROB_TAG_W-1:0] alu_tag_i,
    input  logic [`XLEN-1:0]      alu_data_i,

    // branch writeback
    input  logic                  br_valid_i,
    input  logic [`ROB_TAG_W-1:0] br_tag_i,
    input  logic [`XLEN-1:0]      br_data_i,
    input  logic                  br_taken_i,
    input  logic [`XLEN-1:0]      br_target_i,

    // commit report
    output logic                  commit_valid_o,
    output logic [`REG_ADDR_W-1:0] commit_rd_o,
    output logic [`XLEN-1:0]      commit_data_o,
    output logic [`XLEN-1:0]      commit_pc_o,
    output logic                  flush_o,
    output logic [`XLEN-1:0]      redirect_pc_o,

    // architectural register peek
    input  logic [`REG_ADDR_W-1:0] rs_addr_i,
    output logic [`XLEN-1:0]      rs_data_o
);

    cdb_if      cdb_alu ();
    cdb_if      cdb_br ();
    rob_head_if head_bus ();

    logic                  rf_we;
    logic [`REG_ADDR_W-1:0] rf_waddr;
    logic [`XLEN-1:0]      rf_wdata;

    // alu bus never resolves a branch
    assign cdb_alu.valid     = alu_valid_i;
    assign cdb_alu.tag       = alu_tag_i;
    assign cdb_alu.data      = alu_data_i;
    assign cdb_alu.br_taken  = 1'b0;
    assign cdb_alu.br_target = '0;

    assign cdb_br.valid      = br_valid_i;
    assign cdb_br.tag        = br_tag_i;
    assign cdb_br.data       = br_data_i;
    assign cdb_br.br_taken   = br_taken_i;
    assign cdb_br.br_target  = br_target_i;

    rob u_rob (
        .clk                (clk),
        .rst_n_i            (rst_n_i),
        .dispatch_valid_i   (dispatch_valid_i),
        .dispatch_op_i      (dispatch_op_i),
        .dispatch_pc_i      (dispatch_pc_i),
        .dispatch_rd_i      (dispatch_rd_i),
        .dispatch_regf_we_i (dispatch_regf_we_i),
        .tag_o              (tag_o),
        .full_o             (full_o),
        .cdb_alu            (cdb_alu.rob),
        .cdb_br             (cdb_br.rob),
        .head               (head_bus.rob)
    );

    commit_unit u_commit (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .head           (head_bus.commit),
        .rf_we_o        (rf_we),
        .rf_waddr_o     (rf_waddr),
        .rf_wdata_o     (rf_wdata),
        .commit_valid_o (commit_valid_o),
        .commit_rd_o    (commit_rd_o),
        .commit_data_o  (commit_data_o),
        .commit_pc_o    (commit_pc_o),
        .flush_o        (flush_o),
        .redirect_pc_o  (redirect_pc_o)
    );

    arch_regfile u_regfile (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .we_i    (rf_we),
        .waddr_i (rf_waddr),
        .wdata_i (rf_wdata),
        .raddr_i (rs_addr_i),
        .rdata_o (rs_data_o)
    );

endmodule

// ==== tb_rob_core.sv ====
`timescale 1ns/100ps
`include "rob_core_macros.svh"

module tb_rob_core;

    localparam int CLK_PERIOD      = 100;
    localparam int NUM_TESTS       = 4;
    localparam int CYCLES_PER_TEST = `ROB_DEPTH + 64;
    localparam int RAND_CYCLES     = 40;

    // one instruction in flight, program order kept by queue position
    typedef struct {
        rv32i_pkg::op_class_e   op;
        logic [`ROB_TAG_W-1:0]  tag;
        logic [`XLEN-1:0]       pc;
        logic [`REG_ADDR_W-1:0] rd;
        logic                   regf_we;
        logic                   written;
        logic [`XLEN-1:0]       data;
        logic                   taken;
        logic [`XLEN-1:0]       target;
    } model_entry_t;

    logic                   clk;
    logic                   rst_n_i;
    logic                   dispatch_valid_i;
    rv32i_pkg::op_class_e   dispatch_op_i;
    logic [`XLEN-1:0]       dispatch_pc_i;
    logic [`REG_ADDR_W-1:0] dispatch_rd_i;
    logic                   dispatch_regf_we_i;
    logic [`ROB_TAG_W-1:0]  tag_o;
    logic                   full_o;
    logic                   alu_valid_i;
    logic [`ROB_TAG_W-1:0]  alu_tag_i;
    logic [`XLEN-1:0]       alu_data_i;
    logic                   br_valid_i;
    logic [`ROB_TAG_W-1:0]  br_tag_i;
    logic [`XLEN-1:0]       br_data_i;
    logic                   br_taken_i;
    logic [`XLEN-1:0]       br_target_i;
    logic                   commit_valid_o;
    logic [`REG_ADDR_W-1:0] commit_rd_o;
    logic [`XLEN-1:0]       commit_data_o;
    logic [`XLEN-1:0]       commit_pc_o;
    logic                   flush_o;
    logic [`XLEN-1:0]       redirect_pc_o;
    logic [`REG_ADDR_W-1:0] rs_addr_i;
    logic [`XLEN-1:0]       rs_data_o;

    model_entry_t          model_q [$];
    logic [`XLEN-1:0]      shadow_rf [32];
    logic [31:0]           lfsr;
    logic [`ROB_TAG_W-1:0] exp_tag;
    logic [`XLEN-1:0]      next_pc;
    logic                  wait_flush;
    logic                  full_seen;
    logic                  commit_seen;
    int                    disp_rate;
    int                    wb_rate;
    logic                  taken_ok;
    int                    err_count;
    int                    check_count;
    int                    tests_run;
    int                    tests_failed;
    int                    commits;
    int                    flushes;

    rob_core_top uut (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    // galois lfsr, taps 32 22 2 1, one step per bit handed out
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r    = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        end
        return r;
    endfunction

    task automatic check_hex(input string name, input logic [31:0] got, input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("Error: %s is 0x%08h, expected 0x%08h at %0t", name, got, exp, $time);
        end
    endtask

    // random not-yet-written entry of one bus class, -1 if none
    function automatic int pick_waiting(input logic want_branch);
        int n_wait;
        int pick;
        int idx;
        n_wait = 0;
        idx    = -1;
        foreach (model_q[i]) begin
            if (!model_q[i].written && ((model_q[i].op == rv32i_pkg::op_branch) == want_branch))
                n_wait++;
        end
        if (n_wait == 0)
            return -1;
        pick = rand_bits(4) % n_wait;
        foreach (model_q[i]) begin
            if (!model_q[i].written && ((model_q[i].op == rv32i_pkg::op_branch) == want_branch)) begin
                if (pick == 0 && idx < 0)
                    idx = i;
                pick--;
            end
        end
        return idx;
    endfunction

    // runs at the rising edge, decisions use state sampled at the last falling edge
    task automatic drive_stimulus();
        int                   idx;
        logic [31:0]          r;
        rv32i_pkg::op_class_e op;
        dispatch_valid_i <= 1'b0;
        alu_valid_i      <= 1'b0;
        br_valid_i       <= 1'b0;
        // branch first, a taken one cuts off everything younger
        if (rand_bits(3) < wb_rate) begin
            idx = pick_waiting(1'b1);
            if (idx >= 0) begin
                model_q[idx].written = 1'b1;
                model_q[idx].data    = rand_bits(32);
                model_q[idx].taken   = taken_ok && rand_bits(1);
                r                    = rand_bits(30);
                model_q[idx].target  = {r[29:0], 2'b00};
                br_valid_i  <= 1'b1;
                br_tag_i    <= model_q[idx].tag;
                br_data_i   <= model_q[idx].data;
                br_taken_i  <= model_q[idx].taken;
                br_target_i <= model_q[idx].target;
                if (model_q[idx].taken) begin
                    wait_flush = 1'b1;
                    while (model_q.size() > idx + 1)
                        model_q.delete(model_q.size() - 1);
                end
            end
        end
        if (rand_bits(3) < wb_rate) begin
            idx = pick_waiting(1'b0);
            if (idx >= 0) begin
                model_q[idx].written = 1'b1;
                model_q[idx].data    = rand_bits(32);
                alu_valid_i <= 1'b1;
                alu_tag_i   <= model_q[idx].tag;
                alu_data_i  <= model_q[idx].data;
            end
        end
        // model size never undercounts what the rob holds
        if (!wait_flush && !full_seen && model_q.size() < `ROB_DEPTH
                && rand_bits(3) < disp_rate) begin
            r = rand_bits(2);
            case (r[1:0])
                2'd2:    op = rv32i_pkg::op_branch;
                2'd3:    op = rv32i_pkg::op_nop;
                default: op = rv32i_pkg::op_alu;
            endcase
            dispatch_valid_i <= 1'b1;
            dispatch_op_i    <= op;
            dispatch_pc_i    <= next_pc;
            r = rand_bits(5);
            dispatch_rd_i    <= r[4:0];
            if (op == rv32i_pkg::op_alu)
                dispatch_regf_we_i <= (rand_bits(2) != 0);
            else
                dispatch_regf_we_i <= 1'b0;
            next_pc = next_pc + 4;
        end
        // peek at the rd of the next committer so the new value is seen
        if (model_q.size() > 0) begin
            rs_addr_i <= model_q[0].rd;
        end else begin
            r = rand_bits(5);
            rs_addr_i <= r[4:0];
        end
    endtask

    // runs at the falling edge, outputs stable
    task automatic check_outputs();
        model_entry_t e;
        full_seen   = full_o;
        commit_seen = commit_valid_o;
        if (commit_valid_o && model_q.size() == 0) begin
            err_count++;
            $display("commit reported with no entry outstanding at %0t", $time);
        end else if (commit_valid_o) begin
            e = model_q.pop_front();
            commits++;
            if (!e.written) begin
                err_count++;
                $display("entry with pc 0x%08h committed before its writeback", e.pc);
            end
            check_hex("commit_pc_o", commit_pc_o, e.pc);
            check_hex("commit_rd_o", commit_rd_o, e.rd);
            check_hex("commit_data_o", commit_data_o, e.data);
            if (e.regf_we && e.rd != 0)
                shadow_rf[e.rd] = e.data;
            if (e.op == rv32i_pkg::op_branch && e.taken) begin
                check_hex("flush_o", flush_o, 1);
                check_hex("redirect_pc_o", redirect_pc_o, e.target);
                // tail restarts from slot zero
                check_hex("tag_o", tag_o, 0);
                flushes++;
                wait_flush = 1'b0;
                exp_tag    = '0;
                next_pc    = e.target;
            end else begin
                check_hex("flush_o", flush_o, 0);
            end
        end else begin
            check_hex("flush_o", flush_o, 0);
        end
        // x0 stays zero in the shadow as well
        check_hex("rs_data_o", rs_data_o, shadow_rf[rs_addr_i]);
        if (dispatch_valid_i) begin
            check_hex("tag_o", tag_o, exp_tag);
            e.op      = dispatch_op_i;
            e.tag     = exp_tag;
            e.pc      = dispatch_pc_i;
            e.rd      = dispatch_rd_i;
            e.regf_we = dispatch_regf_we_i;
            e.written = 1'b0;
            e.data    = '0;
            e.taken   = 1'b0;
            e.target  = '0;
            model_q.push_back(e);
            exp_tag   = exp_tag + 1'b1;
        end
    endtask

    task automatic run_cycle();
        @(posedge clk);
        drive_stimulus();
        @(negedge clk);
        check_outputs();
    endtask

    task automatic drain();
        disp_rate = 0;
        wb_rate   = 8;
        while (model_q.size() != 0)
            run_cycle();
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests_run++;
        if (err_count == errs_before) begin
            $display("test %0d %s: ok, %0d commits, %0d flushes", tests_run, name, commits, flushes);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", tests_run, name, err_count - errs_before);
        end
        commits = 0;
        flushes = 0;
    endtask

    initial begin
        int errs_before;
        rst_n_i            = 1'b0;
        dispatch_valid_i   = 1'b0;
        dispatch_op_i      = rv32i_pkg::op_alu;
        dispatch_pc_i      = '0;
        dispatch_rd_i      = '0;
        dispatch_regf_we_i = 1'b0;
        alu_valid_i        = 1'b0;
        alu_tag_i          = '0;
        alu_data_i         = '0;
        br_valid_i         = 1'b0;
        br_tag_i           = '0;
        br_data_i          = '0;
        br_taken_i         = 1'b0;
        br_target_i        = '0;
        rs_addr_i          = '0;
        lfsr               = 32'h4b7e9804;
        exp_tag            = '0;
        next_pc            = 32'h0000_1000;
        wait_flush         = 1'b0;
        full_seen          = 1'b0;
        commit_seen        = 1'b0;
        taken_ok           = 1'b0;
        disp_rate          = 0;
        wb_rate            = 0;
        err_count          = 0;
        check_count        = 0;
        tests_run          = 0;
        tests_failed       = 0;
        commits            = 0;
        flushes            = 0;
        foreach (shadow_rf[i])
            shadow_rf[i] = '0;

        repeat (2) @(posedge clk);
        rst_n_i <= 1'b1;
        @(negedge clk);

        // quiet outputs straight out of reset
        errs_before = err_count;
        check_hex("commit_valid_o", commit_valid_o, 0);
        check_hex("flush_o", flush_o, 0);
        check_hex("full_o", full_o, 0);
        check_hex("tag_o", tag_o, 0);
        check_hex("rs_data_o", rs_data_o, 0);
        report_test("reset_state", errs_before);

        // sixteen allocations, nothing written back
        errs_before = err_count;
        disp_rate   = 8;
        wb_rate     = 0;
        while (model_q.size() < `ROB_DEPTH)
            run_cycle();
        disp_rate = 0;
        run_cycle();
        check_hex("full_o", full_o, 1);
        // one retirement frees a slot
        wb_rate = 8;
        run_cycle();
        while (!commit_seen)
            run_cycle();
        check_hex("full_o", full_o, 0);
        drain();
        report_test("fill_and_full", errs_before);

        // out of order writeback, in order retire
        errs_before = err_count;
        disp_rate   = 5;
        wb_rate     = 5;
        repeat (RAND_CYCLES)
            run_cycle();
        drain();
        report_test("random_in_order", errs_before);

        // taken branches flush and redirect
        errs_before = err_count;
        disp_rate   = 5;
        wb_rate     = 5;
        taken_ok    = 1'b1;
        repeat (RAND_CYCLES)
            run_cycle();
        drain();
        report_test("random_flush", errs_before);

        $display("%0d tests run, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, check_count, err_count);
        if (tests_failed == 0 && err_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    // bound on the whole run
    initial begin
        repeat (NUM_TESTS * CYCLES_PER_TEST) @(posedge clk);
        $display("timeout, run still busy after %0d cycles", NUM_TESTS * CYCLES_PER_TEST);
        $display("Verification failed");
        $finish;
    end

endmodule

// ==== rob_core.f ====
+incdir+.
rv32i_pkg.sv
rob_pkg.sv
cdb_if.sv
rob_head_if.sv
rob.sv
commit_unit.sv
arch_regfile.sv
rob_core_top.sv
tb_rob_core.sv

// ==== Bender.yml ====
package:
  name: rob_core

sources:
  - include_dirs:
      - .
    files:
      - rv32i_pkg.sv
      - rob_pkg.sv
      - cdb_if.sv
      - rob_head_if.sv
      - rob.sv
      - commit_unit.sv
      - arch_regfile.sv
      - rob_core_top.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_rob_core.sv
